// ==== files.f ====
src/p_jtb.sv
src/jtb_ifs.sv
src/fast_adder_2.sv
src/jtb_way.sv
src/jtb_update_ctrl.sv
src/jtb_hit_select.sv
src/jump_predictor.sv
verification/tb_jump_predictor.sv

// ==== run.sh ====
#!/bin/sh
# build and run the jump predictor testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_jump_predictor \
   -f files.f -o sim_jtb
./obj_dir/sim_jtb 2>&1 | tee sim.log
if grep -q "Errors found" sim.log; then
   echo "simulation failed"
   exit 1
fi
grep -q "No errors" sim.log
echo "simulation passed"

// ==== src/fast_adder_2.sv ====
`default_nettype none

module fast_adder_2 import p_jtb::*; (
   input  logic [30:0] s_base_val_i,              // halfword base address
   input  jtb_offset_t s_add_val_i,               // signed halfword offset
   output logic [30:0] s_val_o                    // base plus sign-extended offset
);
   localparam int HI_W = 31 - OFFSET_WIDTH;       // bits above the offset field

   logic [OFFSET_WIDTH:0] s_sum_lo;               // low sum with carry out
   logic [HI_W-1:0]       s_hi_inc, s_hi_dec;     // precomputed upper candidates
   logic [HI_W-1:0]       s_hi;                   // selected upper part
   logic                  s_sign, s_carry;

   // low half in one ripple, upper half as carry select
   assign s_sum_lo = {1'b0, s_base_val_i[OFFSET_WIDTH-1:0]} + {1'b0, s_add_val_i};
   assign s_carry  = s_sum_lo[OFFSET_WIDTH];
   assign s_sign   = s_add_val_i[OFFSET_WIDTH-1];  // negative offset adds all ones above

   assign s_hi_inc = s_base_val_i[30:OFFSET_WIDTH] + 1'b1;
   assign s_hi_dec = s_base_val_i[30:OFFSET_WIDTH] - 1'b1;

   always_comb begin : hi_select
      case ({s_sign, s_carry})
         2'b01:   s_hi = s_hi_inc;                // positive, carry in
         2'b10:   s_hi = s_hi_dec;                // negative, no carry
         default: s_hi = s_base_val_i[30:OFFSET_WIDTH];   // carry cancels the sign
      endcase
   end

   assign s_val_o = {s_hi, s_sum_lo[OFFSET_WIDTH-1:0]};

endmodule

`default_nettype wire

// ==== src/jtb_hit_select.sv ====
`default_nettype none

module jtb_hit_select import p_jtb::*; #(
   parameter int SETS   = 8,                      // sets per way
   parameter int WAYS   = 2,                      // number of ways
   parameter int SHARED = 8                       // upper address bits not stored
) (
   input  logic [30:0] s_fetch_add_i,             // halfword fetch address
   jtb_lookup_if.sel   lkp,                       // results from the ways
   output logic        s_ualigc_o,                // predicted jump is unaligned rvc
   output logic        s_pred_jump_o,             // jump fetched
   output logic [31:0] s_pred_add_o               // predicted target, byte address
);
   localparam int IDX_W = $clog2(SETS);

   jtb_entry_t  s_hit_entry;                      // entry of the hitting way
   logic        s_any_hit;
   logic [30:0] s_tadd;                           // halfword target

   // fetch address decode
   assign lkp.fetch_index = s_fetch_add_i[IDX_W:1];
   assign lkp.fetch_tag   = s_fetch_add_i[30-SHARED:IDX_W+1];

   // and-or mux, hit vector is one-hot or empty
   always_comb begin : entry_mux
      s_hit_entry = '0;
      for (int w = 0; w < WAYS; w++) begin
         s_hit_entry = s_hit_entry | (lkp.entry[w] & {$bits(jtb_entry_t){lkp.hit[w]}});
      end
   end

   assign s_any_hit = |lkp.hit;

   // aligned fetch, or unaligned with the rvc flag stored
   assign s_pred_jump_o = s_any_hit & (~s_fetch_add_i[0] | s_hit_entry.ualigc);
   assign s_ualigc_o    = s_hit_entry.ualigc;

   // ualigc selects the upper halfword of an unaligned rvc
   fast_adder_2 m_fa_tadd (
      .s_base_val_i ({s_fetch_add_i[30:1], s_hit_entry.ualigc}),
      .s_add_val_i  (s_hit_entry.offset),
      .s_val_o      (s_tadd)
   );

   assign s_pred_add_o = {s_tadd, 1'b0};          // back to byte address

   always_comb begin : hit_check
      a_hit_onehot: assert ($onehot0(lkp.hit))
         else $error("jtb_hit_select: several ways hit %b", lkp.hit);
   end

endmodule

`default_nettype wire

// ==== src/jtb_ifs.sv ====
`default_nettype none

// controller to ways, with probe results flowing back
interface jtb_update_if import p_jtb::*; #(
   parameter int SETS   = 8,                      // sets per way
   parameter int WAYS   = 2,                      // number of ways
   parameter int SHARED = 8                       // upper address bits not stored
);
   localparam int IDX_W = $clog2(SETS);           // set index width
   localparam int TAG_W = 32 - IDX_W - 2 - SHARED;   // stored base tag width

   logic [IDX_W-1:0]   index;                     // set addressed by the update
   logic [TAG_W-1:0]   tag;                       // base tag of the executed jump
   jtb_entry_t         entry;                     // offset and rvc flag to store
   jtb_op_e [WAYS-1:0] op;                        // one command per way
   wire [WAYS-1:0]     probe_hit;                 // valid entry with matching tag
   wire [WAYS-1:0]     probe_valid;               // indexed set occupied

   modport ctrl (
      output index, tag, entry, op,
      input  probe_hit, probe_valid
   );

   modport way (
      input  index, tag, entry, op,
      output probe_hit, probe_valid
   );

endinterface

// ways to hit selector, fetch side
interface jtb_lookup_if import p_jtb::*; #(
   parameter int SETS   = 8,                      // sets per way
   parameter int WAYS   = 2,                      // number of ways
   parameter int SHARED = 8                       // upper address bits not stored
);
   localparam int IDX_W = $clog2(SETS);           // set index width
   localparam int TAG_W = 32 - IDX_W - 2 - SHARED;   // compared tag width

   logic [IDX_W-1:0]      fetch_index;            // set read by the fetch address
   logic [TAG_W-1:0]      fetch_tag;              // tag of the fetch address
   wire [WAYS-1:0]        hit;                    // per-way lookup hit
   wire jtb_entry_t [WAYS-1:0] entry;             // per-way indexed entry

   modport way (
      input  fetch_index, fetch_tag,
      output hit, entry
   );

   modport sel (
      output fetch_index, fetch_tag,
      input  hit, entry
   );

endinterface

`default_nettype wire

// ==== src/jtb_update_ctrl.sv ====
`default_nettype none

module jtb_update_ctrl import p_jtb::*; #(
   parameter int SETS   = 8,                      // sets per way
   parameter int WAYS   = 2,                      // number of ways
   parameter int SHARED = 8                       // upper address bits not stored
) (
   input logic        s_clk_i,                    // clock
   input logic        s_resetn_i,                 // sync reset, active low
   input logic        s_invalidate_i,             // clear indexed set in all ways
   input logic        s_jump_update_i,            // store executed jump
   input logic        s_ualigc_i,                 // jump is unaligned rvc
   input jtb_offset_t s_jump_offset_i,            // target offset in halfwords
   input logic [31:0] s_jump_add_i,               // byte address of the jump
   jtb_update_if.ctrl upd                         // to every way
);
   localparam int IDX_W = $clog2(SETS);
   localparam int TAG_W = 32 - IDX_W - 2 - SHARED;
   localparam int VIC_W = (WAYS > 1) ? $clog2(WAYS) : 1;   // victim pointer width

   logic [VIC_W-1:0]   s_victim_q;                // global round-robin pointer
   logic [WAYS-1:0]    s_free_way;                // lowest invalid way, one-hot
   logic [WAYS-1:0]    s_sel_way;                 // way chosen for the write
   logic               s_use_victim;              // full set, no tag match
   jtb_op_e [WAYS-1:0] s_op;

   // address split, bits 1:0 and the shared top are dropped
   assign upd.index = s_jump_add_i[IDX_W+1:2];
   assign upd.tag   = s_jump_add_i[31-SHARED:IDX_W+2];
   assign upd.entry = '{ualigc: s_ualigc_i, offset: s_jump_offset_i};

   // lowest numbered invalid way wins
   always_comb begin : free_search
      s_free_way = '0;
      for (int i = WAYS - 1; i >= 0; i--) begin
         if (!upd.probe_valid[i]) begin
            s_free_way    = '0;
            s_free_way[i] = 1'b1;
         end
      end
   end

   // replacement rule: matching tag, then free way, then victim
   always_comb begin : way_select
      s_sel_way    = '0;
      s_use_victim = 1'b0;
      if (|upd.probe_hit) begin
         s_sel_way = upd.probe_hit;               // overwrite own entry
      end else if (!(&upd.probe_valid)) begin
         s_sel_way = s_free_way;
      end else begin
         s_sel_way[s_victim_q] = 1'b1;            // evict round robin
         s_use_victim          = 1'b1;
      end
   end

   // invalidate beats update
   always_comb begin : op_drive
      for (int w = 0; w < WAYS; w++) begin
         if (s_invalidate_i) begin
            s_op[w] = JTB_CLEAR;
         end else if (s_jump_update_i && s_sel_way[w]) begin
            s_op[w] = JTB_WRITE;
         end else begin
            s_op[w] = JTB_IDLE;
         end
      end
   end

   assign upd.op = s_op;

   // pointer moves only on an eviction
   always_ff @(posedge s_clk_i) begin : victim_update
      if (!s_resetn_i) begin
         s_victim_q <= '0;
      end else if (s_jump_update_i && !s_invalidate_i && s_use_victim) begin
         if (s_victim_q == VIC_W'(WAYS - 1)) begin
            s_victim_q <= '0;                     // wrap modulo ways
         end else begin
            s_victim_q <= s_victim_q + 1'b1;
         end
      end
   end

   // replacement never lets one tag live in two ways of a set
   a_probe_onehot: assert property (@(posedge s_clk_i) disable iff (!s_resetn_i)
      $onehot0(upd.probe_hit))
      else $error("jtb_update_ctrl: tag present in several ways %b", upd.probe_hit);

endmodule

`default_nettype wire

// ==== src/jtb_way.sv ====
`default_nettype none

module jtb_way import p_jtb::*; #(
   parameter int WAY    = 0,                      // position of this way
   parameter int SETS   = 8,                      // sets in the way
   parameter int SHARED = 8                       // upper address bits not stored
) (
   input logic       s_clk_i,                     // clock
   input logic       s_resetn_i,                  // active low sync reset
   jtb_update_if.way upd,                         // update port from controller
   jtb_lookup_if.way lkp                          // lookup port to selector
);
   localparam int IDX_W = $clog2(SETS);
   localparam int TAG_W = 32 - IDX_W - 2 - SHARED;

   logic [SETS-1:0]  s_valid_q;                   // valid bit per set
   logic [TAG_W-1:0] s_tag_q [SETS];              // stored base tags
   jtb_entry_t       s_entry_q [SETS];            // stored offset and flag
   logic [SETS-1:0]  s_set_sel;                   // one-hot update set
   jtb_op_e          s_op;                        // command for this way
   logic [TAG_W-1:0] s_lkp_tag, s_upd_tag;        // tags read at both indices
   logic             s_lkp_valid, s_upd_valid;

   assign s_op      = upd.op[WAY];
   assign s_set_sel = SETS'(1) << upd.index;

   // per-set valid bits
   always_ff @(posedge s_clk_i) begin : valid_update
      if (!s_resetn_i) begin
         s_valid_q <= '0;                         // empty buffer
      end else begin
         case (s_op)
            JTB_CLEAR: s_valid_q <= s_valid_q & ~s_set_sel;
            JTB_WRITE: s_valid_q <= s_valid_q | s_set_sel;
            default:   s_valid_q <= s_valid_q;
         endcase
      end
   end

   // tag and payload storage
   always_ff @(posedge s_clk_i) begin : entry_write
      if (s_op == JTB_WRITE) begin
         s_tag_q[upd.index]   <= upd.tag;         // base tag of the jump
         s_entry_q[upd.index] <= upd.entry;       // offset and rvc flag
      end
   end

   // fetch side compare
   assign s_lkp_valid      = s_valid_q[lkp.fetch_index];
   assign s_lkp_tag        = s_tag_q[lkp.fetch_index];
   assign lkp.hit[WAY]     = s_lkp_valid & (s_lkp_tag == lkp.fetch_tag);
   assign lkp.entry[WAY]   = s_entry_q[lkp.fetch_index];   // read even on miss

   // update side probe for the replacement choice
   assign s_upd_valid         = s_valid_q[upd.index];
   assign s_upd_tag           = s_tag_q[upd.index];
   assign upd.probe_valid[WAY] = s_upd_valid;
   assign upd.probe_hit[WAY]   = s_upd_valid & (s_upd_tag == upd.tag);

   // command from the controller stays within the enum
   a_op_legal: assert property (@(posedge s_clk_i) disable iff (!s_resetn_i)
      s_op inside {JTB_IDLE, JTB_WRITE, JTB_CLEAR})
      else $error("jtb_way %0d: illegal op %b", WAY, s_op);

endmodule

`default_nettype wire

// ==== src/jump_predictor.sv ====
`default_nettype none

module jump_predictor import p_jtb::*; #(
   parameter int SETS   = 8,                      // sets per way
   parameter int WAYS   = 2,                      // number of ways
   parameter int SHARED = 8                       // upper address bits not stored
) (
   input  logic        s_clk_i,                   // clock
   input  logic        s_resetn_i,                // sync reset, clears all entries
   input  logic        s_invalidate_i,            // clear set of s_jump_add_i
   input  logic [30:0] s_fetch_add_i,             // halfword fetch address

   input  logic        s_jump_update_i,           // store executed jump
   input  logic        s_ualigc_i,                // executed jump is unaligned rvc
   input  jtb_offset_t s_jump_offset_i,           // target offset in halfwords
   input  logic [31:0] s_jump_add_i,              // byte address of the jump

   output logic        s_ualigc_o,                // predicted jump is unaligned rvc
   output logic        s_pred_jump_o,             // jump predicted
   output logic [31:0] s_pred_add_o               // predicted target
);

   jtb_update_if #(.SETS(SETS), .WAYS(WAYS), .SHARED(SHARED)) m_upd_if ();
   jtb_lookup_if #(.SETS(SETS), .WAYS(WAYS), .SHARED(SHARED)) m_lkp_if ();

   // write side, replacement and victim pointer
   jtb_update_ctrl #(
      .SETS   (SETS),
      .WAYS   (WAYS),
      .SHARED (SHARED)
   ) m_upd_ctrl (
      .s_clk_i         (s_clk_i),
      .s_resetn_i      (s_resetn_i),
      .s_invalidate_i  (s_invalidate_i),
      .s_jump_update_i (s_jump_update_i),
      .s_ualigc_i      (s_ualigc_i),
      .s_jump_offset_i (s_jump_offset_i),
      .s_jump_add_i    (s_jump_add_i),
      .upd             (m_upd_if)
   );

   // storage, one copy per way
   for (genvar w = 0; w < WAYS; w++) begin : g_way
      jtb_way #(
         .WAY    (w),
         .SETS   (SETS),
         .SHARED (SHARED)
      ) m_way (
         .s_clk_i    (s_clk_i),
         .s_resetn_i (s_resetn_i),
         .upd        (m_upd_if),
         .lkp        (m_lkp_if)
      );
   end

   // same-cycle prediction and target
   jtb_hit_select #(
      .SETS   (SETS),
      .WAYS   (WAYS),
      .SHARED (SHARED)
   ) m_hit_sel (
      .s_fetch_add_i (s_fetch_add_i),
      .lkp           (m_lkp_if),
      .s_ualigc_o    (s_ualigc_o),
      .s_pred_jump_o (s_pred_jump_o),
      .s_pred_add_o  (s_pred_add_o)
   );

endmodule

`default_nettype wire

// ==== src/p_jtb.sv ====
`default_nettype none

package p_jtb;

   // jump offset field, halfword granule
   localparam int OFFSET_WIDTH = 20;               // bits of stored offset

   typedef logic signed [OFFSET_WIDTH-1:0] jtb_offset_t;   // signed offset in halfwords

   // per-way update command from the controller
   typedef enum logic [1:0] {
      JTB_IDLE  = 2'b00,                           // hold set contents
      JTB_WRITE = 2'b01,                           // store tag and entry, set valid
      JTB_CLEAR = 2'b10                            // drop valid of indexed set
   } jtb_op_e;

   // payload kept per set next to the tag
   typedef struct packed {
      logic        ualigc;                         // jump is unaligned rvc
      jtb_offset_t offset;                         // target offset
   } jtb_entry_t;

endpackage

`default_nettype wire

// ==== verification/tb_jump_predictor.sv ====
`default_nettype none

module tb_jump_predictor import p_jtb::*; ();
   localparam int SETS          = 8;
   localparam int WAYS          = 2;
   localparam int SHARED        = 8;
   localparam int IDX_W         = $clog2(SETS);
   localparam int TAG_W         = 32 - IDX_W - 2 - SHARED;
   localparam int MAX_CYCLES    = 400;            // whole run
   localparam int RESET_TIMEOUT = 20;             // cycles to leave reset

   typedef enum logic [1:0] {ROW_WRITE, ROW_CLEAR, ROW_BOTH, ROW_LOOKUP} row_op_e;

   typedef struct packed {
      row_op_e     op;
      logic [31:0] add;                           // byte address of jump or fetch
      jtb_offset_t offset;
      logic        ualigc;
      logic        pred;                          // expected s_pred_jump_o
   } row_t;

   logic        s_clk_i = 1'b0;
   logic        s_resetn_i, s_invalidate_i, s_jump_update_i, s_ualigc_i;
   logic [30:0] s_fetch_add_i;
   jtb_offset_t s_jump_offset_i;
   logic [31:0] s_jump_add_i;
   logic        s_ualigc_o, s_pred_jump_o;
   logic [31:0] s_pred_add_o;

   row_t             rows[$];                     // stimulus table
   logic [31:0]      lcg_state;
   logic             m_valid  [SETS][WAYS];       // reference model of the buffer
   logic [TAG_W-1:0] m_tag    [SETS][WAYS];
   logic             m_ualigc [SETS][WAYS];
   jtb_offset_t      m_off    [SETS][WAYS];
   int               m_victim;                    // round-robin pointer of the model

   jump_predictor #(.SETS(SETS), .WAYS(WAYS), .SHARED(SHARED)) u_dut (
      .s_clk_i         (s_clk_i),
      .s_resetn_i      (s_resetn_i),
      .s_invalidate_i  (s_invalidate_i),
      .s_fetch_add_i   (s_fetch_add_i),
      .s_jump_update_i (s_jump_update_i),
      .s_ualigc_i      (s_ualigc_i),
      .s_jump_offset_i (s_jump_offset_i),
      .s_jump_add_i    (s_jump_add_i),
      .s_ualigc_o      (s_ualigc_o),
      .s_pred_jump_o   (s_pred_jump_o),
      .s_pred_add_o    (s_pred_add_o)
   );

   always #5 s_clk_i = ~s_clk_i;                  // period 10

   task automatic abort_run();
      $display("Errors found");
      $fatal(1, "run stopped");
   endtask

   task automatic check_bit(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         $display("Error at time %0t: %s is %b, expected %b", $time, name, act, exp);
         abort_run();
      end
   endtask

   task automatic check_add(input string name, input logic [31:0] act, input logic [31:0] exp);
      if (act !== exp) begin
         $display("Error at time %0t: %s is %h, expected %h", $time, name, act, exp);
         abort_run();
      end
   endtask

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic next_offset(output jtb_offset_t off);
      lcg_state = lcg_next(lcg_state);
      off = jtb_offset_t'(lcg_state[30:11]);      // upper bits spread better
   endtask

   // byte address built from its fields top to bottom
   function automatic logic [31:0] make_add(input logic [SHARED-1:0] shr,
                                            input logic [TAG_W-1:0] tag,
                                            input logic [IDX_W-1:0] idx, input logic half);
      return {shr, tag, idx, half, 1'b0};
   endfunction

   task automatic add_row(input row_op_e op, input logic [31:0] add, input jtb_offset_t offset,
                          input logic ualigc, input logic pred);
      rows.push_back('{op, add, offset, ualigc, pred});
   endtask

   task automatic init_model();
      m_victim = 0;
      for (int s = 0; s < SETS; s++) begin
         for (int w = 0; w < WAYS; w++) begin
            m_valid[s][w] = 1'b0;
         end
      end
   endtask

   // matching tag goes before a free way and the victim pointer comes last
   task automatic store_jump(input logic [31:0] add, input jtb_offset_t off, input logic ua);
      logic [IDX_W-1:0] idx;
      logic [TAG_W-1:0] tag;
      int               way;
      idx = add[IDX_W+1:2];
      tag = add[31-SHARED:IDX_W+2];
      way = -1;
      for (int w = 0; w < WAYS; w++) begin
         if (way < 0 && m_valid[idx][w] && m_tag[idx][w] == tag) way = w;
      end
      for (int w = 0; w < WAYS; w++) begin
         if (way < 0 && !m_valid[idx][w]) way = w;
      end
      if (way < 0) begin
         way      = m_victim;
         m_victim = (m_victim + 1) % WAYS;
      end
      m_valid[idx][way]  = 1'b1;
      m_tag[idx][way]    = tag;
      m_ualigc[idx][way] = ua;
      m_off[idx][way]    = off;
   endtask

   task automatic clear_set(input logic [31:0] add);
      for (int w = 0; w < WAYS; w++) begin
         m_valid[add[IDX_W+1:2]][w] = 1'b0;       // every way of the set
      end
   endtask

   task automatic predict_fetch(input logic [31:0] add, output logic hit, output logic pred,
                                output logic ua, output logic [31:0] target);
      logic [IDX_W-1:0] idx;
      logic [TAG_W-1:0] tag;
      logic [31:0]      sum;
      jtb_offset_t      off;
      idx = add[IDX_W+1:2];
      tag = add[31-SHARED:IDX_W+2];
      hit = 1'b0;
      ua  = 1'b0;
      off = '0;
      for (int w = 0; w < WAYS; w++) begin
         if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
            hit = 1'b1;
            ua  = m_ualigc[idx][w];
            off = m_off[idx][w];
         end
      end
      pred   = hit && (!add[1] || ua);            // unaligned fetch needs the rvc flag
      sum    = {1'b0, add[31:2], ua} + {{(32-OFFSET_WIDTH){off[OFFSET_WIDTH-1]}}, off};
      target = {sum[30:0], 1'b0};                 // halfword sum back to bytes
   endtask

   task automatic build_table();
      jtb_offset_t off_a, off_b, off_c;
      // nothing predicts after reset
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h12345, 3'd3, 1'b0), '0, 1'b0, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h00000, 3'd0, 1'b0), '0, 1'b0, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'hff, 19'h7ffff, 3'd7, 1'b1), '0, 1'b0, 1'b0);
      // single aligned and unaligned entries
      add_row(ROW_WRITE,  make_add(8'h00, 19'h00100, 3'd1, 1'b0), 20'sh00040, 1'b0, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h00100, 3'd1, 1'b0), '0, 1'b0, 1'b1);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h00100, 3'd1, 1'b1), '0, 1'b0, 1'b0);
      add_row(ROW_WRITE,  make_add(8'h00, 19'h00200, 3'd2, 1'b1), -20'sd5, 1'b1, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h00200, 3'd2, 1'b1), '0, 1'b0, 1'b1);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h00200, 3'd2, 1'b0), '0, 1'b0, 1'b1);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h00201, 3'd2, 1'b0), '0, 1'b0, 1'b0);
      // rewrite in place in set 5 then fill the second way
      add_row(ROW_WRITE,  make_add(8'h00, 19'h01000, 3'd5, 1'b0), 20'sh00100, 1'b0, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h01000, 3'd5, 1'b0), '0, 1'b0, 1'b1);
      add_row(ROW_WRITE,  make_add(8'h00, 19'h01000, 3'd5, 1'b0), 20'sh80000, 1'b0, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h01000, 3'd5, 1'b0), '0, 1'b0, 1'b1);
      add_row(ROW_WRITE,  make_add(8'h00, 19'h02000, 3'd5, 1'b0), 20'sh7ffff, 1'b0, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h01000, 3'd5, 1'b0), '0, 1'b0, 1'b1);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h02000, 3'd5, 1'b0), '0, 1'b0, 1'b1);
      // evictions from the full set follow the pointer
      next_offset(off_a);
      add_row(ROW_WRITE,  make_add(8'h00, 19'h03000, 3'd5, 1'b0), off_a, 1'b0, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h03000, 3'd5, 1'b0), '0, 1'b0, 1'b1);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h01000, 3'd5, 1'b0), '0, 1'b0, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h02000, 3'd5, 1'b0), '0, 1'b0, 1'b1);
      next_offset(off_b);
      add_row(ROW_WRITE,  make_add(8'h00, 19'h04000, 3'd5, 1'b0), off_b, 1'b0, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h04000, 3'd5, 1'b0), '0, 1'b0, 1'b1);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h02000, 3'd5, 1'b0), '0, 1'b0, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h03000, 3'd5, 1'b0), '0, 1'b0, 1'b1);
      // invalidate alone and together with an update
      add_row(ROW_CLEAR,  make_add(8'h00, 19'h00000, 3'd5, 1'b0), '0, 1'b0, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h03000, 3'd5, 1'b0), '0, 1'b0, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h04000, 3'd5, 1'b0), '0, 1'b0, 1'b0);
      add_row(ROW_WRITE,  make_add(8'h00, 19'h00300, 3'd2, 1'b0), 20'sh00010, 1'b0, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h00300, 3'd2, 1'b0), '0, 1'b0, 1'b1);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h00200, 3'd2, 1'b1), '0, 1'b0, 1'b1);
      add_row(ROW_BOTH,   make_add(8'h00, 19'h00400, 3'd2, 1'b0), 20'sh00022, 1'b0, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h00200, 3'd2, 1'b0), '0, 1'b0, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h00300, 3'd2, 1'b0), '0, 1'b0, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h00400, 3'd2, 1'b0), '0, 1'b0, 1'b0);
      // top address bits alias
      add_row(ROW_WRITE,  make_add(8'h00, 19'h00555, 3'd6, 1'b0), 20'sh00123, 1'b0, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'ha5, 19'h00555, 3'd6, 1'b0), '0, 1'b0, 1'b1);
      add_row(ROW_LOOKUP, make_add(8'hff, 19'h00555, 3'd6, 1'b0), '0, 1'b0, 1'b1);
      next_offset(off_c);
      add_row(ROW_WRITE,  make_add(8'h3c, 19'h00666, 3'd7, 1'b1), off_c, 1'b1, 1'b0);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h00666, 3'd7, 1'b1), '0, 1'b0, 1'b1);
      add_row(ROW_LOOKUP, make_add(8'h81, 19'h00666, 3'd7, 1'b0), '0, 1'b0, 1'b1);
      add_row(ROW_LOOKUP, make_add(8'h00, 19'h00100, 3'd1, 1'b0), '0, 1'b0, 1'b1);   // untouched set
   endtask

   task automatic wait_reset_release();
      int cnt;
      cnt = 0;
      while (s_resetn_i !== 1'b1 && cnt < RESET_TIMEOUT) begin
         @(posedge s_clk_i);
         cnt++;
      end
      if (s_resetn_i !== 1'b1) begin
         $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
         abort_run();
      end
   endtask

   // one row per cycle with single-cycle strobes
   task automatic apply_row(input int num, input row_t row);
      logic        exp_hit, exp_pred, exp_ua;
      logic [31:0] exp_add;
      @(posedge s_clk_i);
      #1;
      s_jump_update_i = 1'b0;
      s_invalidate_i  = 1'b0;
      case (row.op)
         ROW_WRITE, ROW_BOTH: begin
            s_jump_update_i = 1'b1;
            s_invalidate_i  = (row.op == ROW_BOTH);   // invalidate wins
            s_jump_add_i    = row.add;
            s_jump_offset_i = row.offset;
            s_ualigc_i      = row.ualigc;
            if (row.op == ROW_BOTH) clear_set(row.add);
            else store_jump(row.add, row.offset, row.ualigc);
         end
         ROW_CLEAR: begin
            s_invalidate_i = 1'b1;
            s_jump_add_i   = row.add;
            clear_set(row.add);
         end
         default: begin
            s_fetch_add_i = row.add[31:1];        // halfword fetch address
            #4;                                   // mid cycle once outputs settle
            predict_fetch(row.add, exp_hit, exp_pred, exp_ua, exp_add);
            if (exp_pred !== row.pred) begin
               $display("Stimulus table and reference model disagree on row %0d", num);
               abort_run();
            end
            check_bit("s_pred_jump_o", s_pred_jump_o, row.pred);
            if (exp_hit) check_bit("s_ualigc_o", s_ualigc_o, exp_ua);
            if (row.pred) check_add("s_pred_add_o", s_pred_add_o, exp_add);
         end
      endcase
   endtask

   initial begin : reset_gen
      s_resetn_i = 1'b0;
      repeat (2) @(posedge s_clk_i);
      #1 s_resetn_i = 1'b1;
   end

   initial begin : watchdog
      for (int c = 0; c < MAX_CYCLES; c++) begin
         @(posedge s_clk_i);
      end
      $display("Timeout: run did not end within %0d cycles", MAX_CYCLES);
      abort_run();
   end

   initial begin : main_seq
      s_invalidate_i  = 1'b0;
      s_jump_update_i = 1'b0;
      s_ualigc_i      = 1'b0;
      s_jump_offset_i = '0;
      s_jump_add_i    = '0;
      s_fetch_add_i   = '0;
      lcg_state       = 32'd89;                   // fixed seed
      init_model();
      build_table();
      wait_reset_release();
      for (int i = 0; i < rows.size(); i++) begin
         apply_row(i, rows[i]);
      end
      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire
